// ==== memory_game.f ====
design/game_pkg.sv
design/sequence_rom.sv
design/game_datapath.sv
design/play_timer.sv
design/game_control.sv
design/memory_game.sv
verif/memory_game_checker.sv
verif/tb_memory_game.sv

// ==== Makefile ====
# Verilator build and run of the memory game testbench

SOURCES := $(shell cat memory_game.f)

.PHONY: all run clean

all: obj_dir/Vtb_memory_game

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_memory_game: memory_game.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_memory_game -f memory_game.f

# Exit status of the simulator gives pass or fail
run: obj_dir/Vtb_memory_game
	./obj_dir/Vtb_memory_game

clean:
	rm -rf obj_dir

// ==== verif/tb_memory_game.sv ====
// Memory game testbench driving LCG chosen games and checking them against a play model
`timescale 1ns/100ps

module tb_memory_game;

    localparam int timeout_cycles = 40;
    localparam int wait_limit     = 2000;
    localparam int game_count     = 30;

    // How a game is meant to end
    localparam int mode_win     = 0;
    localparam int mode_wrong   = 1;
    localparam int mode_timeout = 2;

    logic                             clock;
    logic                             rst_n;
    logic                             start;
    logic [game_pkg::key_width-1:0]   keys;
    logic                             level;
    logic                             done;
    logic                             won;
    logic                             lost;
    logic                             timed_out;
    logic [game_pkg::key_width-1:0]   play;
    logic [game_pkg::round_width-1:0] round;

    int unsigned lcg_state;

    memory_game #(
        .timeout_cycles (timeout_cycles)
    ) i_memory_game (
        .clock     (clock),
        .rst_n     (rst_n),
        .start     (start),
        .keys      (keys),
        .level     (level),
        .done      (done),
        .won       (won),
        .lost      (lost),
        .timed_out (timed_out),
        .play      (play),
        .round     (round)
    );

    // Assertions sit on the control FSM
    bind game_control memory_game_checker i_memory_game_checker (
        .clock       (clock),
        .rst_n       (rst_n),
        .count_round (count_round),
        .clear_round (clear_round),
        .timer_run   (timer_run),
        .done        (done),
        .won         (won),
        .lost        (lost),
        .timed_out   (timed_out)
    );

    // 4 ns period
    always #2 clock = ~clock;

    // LCG step with the result folded into lo..hi
    function automatic int unsigned rand_range(input int unsigned lo, input int unsigned hi);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lo + ((lcg_state >> 16) % (hi - lo + 1));
    endfunction

    // Inputs change just after the rising edge
    task automatic next_cycle();
        @(posedge clock);
        #0.5;
    endtask

    task automatic check_value(input string name, input int unsigned expected,
                               input int unsigned actual);
        if (expected != actual) begin
            $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "Simulation stopped at the first mismatch");
        end
    endtask

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Until the game ends or the round moves on
    task automatic wait_response(input int round_before, input string tag);
        int cycles;
        cycles = 0;
        while (!done && (int'(round) == round_before)) begin
            if (cycles == wait_limit) begin
                report_failure($sformatf("%s: no response from the game within %0d cycles",
                                         tag, wait_limit));
            end
            next_cycle();
            cycles++;
        end
    endtask

    task automatic run_game(input int game, input logic long_level, input int mode,
                            input int err_round, input logic long_hold);
        int                             n;
        int                             gap;
        int                             hold;
        logic [game_pkg::key_width-1:0] value;
        logic [game_pkg::key_width-1:0] seq_word;
        string                          tag;
        n = long_level ? game_pkg::rounds_long : game_pkg::rounds_short;
        // Level stays driven for the whole game
        level = long_level;
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        next_cycle();
        // Fresh game at round 0 after prepare
        tag = $sformatf("game %0d start", game);
        check_value({tag, " done"}, 0, 32'(done));
        check_value({tag, " timed_out"}, 0, 32'(timed_out));
        check_value({tag, " round"}, 0, 32'(round));
        check_value({tag, " play"}, 0, 32'(play));
        for (int i = 0; i < n; i++) begin
            tag = $sformatf("game %0d round %0d", game, i);
            seq_word = game_pkg::game_sequence[i];
            if ((mode == mode_timeout) && (i == err_round)) begin
                // Keys withheld so the timer ends the game
                wait_response(i, tag);
                check_value({tag, " lost"}, 1, 32'(lost));
                check_value({tag, " won"}, 0, 32'(won));
                check_value({tag, " timed_out"}, 1, 32'(timed_out));
                check_value({tag, " round"}, i, 32'(round));
                if (i == 0) begin
                    check_value({tag, " play"}, 0, 32'(play));
                end else begin
                    check_value({tag, " play"}, 32'(game_pkg::game_sequence[i-1]), 32'(play));
                end
                return;
            end
            value = seq_word;
            if ((mode == mode_wrong) && (i == err_round)) begin
                // Non-zero and never the stored word
                value = 4'(rand_range(1, 15));
                if (value == seq_word) begin
                    value = 4'((int'(value) % 15) + 1);
                end
            end
            gap = int'(rand_range(1, 10));
            repeat (gap) next_cycle();
            // Nothing may have moved while keys were idle
            check_value({tag, " done before play"}, 0, 32'(done));
            check_value({tag, " round before play"}, i, 32'(round));
            hold = long_hold ? int'(rand_range(12, 16)) : int'(rand_range(2, 6));
            keys = value;
            repeat (hold) next_cycle();
            keys = '0;
            wait_response(i, tag);
            if (value != seq_word) begin
                check_value({tag, " lost"}, 1, 32'(lost));
                check_value({tag, " won"}, 0, 32'(won));
                check_value({tag, " timed_out"}, 0, 32'(timed_out));
                check_value({tag, " round"}, i, 32'(round));
                check_value({tag, " play"}, 32'(value), 32'(play));
                return;
            end else if (i == n - 1) begin
                check_value({tag, " won"}, 1, 32'(won));
                check_value({tag, " lost"}, 0, 32'(lost));
                check_value({tag, " timed_out"}, 0, 32'(timed_out));
                check_value({tag, " round"}, n - 1, 32'(round));
                check_value({tag, " play"}, 32'(seq_word), 32'(play));
                return;
            end else begin
                check_value({tag, " done"}, 0, 32'(done));
                check_value({tag, " round"}, i + 1, 32'(round));
                check_value({tag, " play"}, 32'(seq_word), 32'(play));
            end
        end
    endtask

    initial begin
        logic long_level;
        logic long_hold;
        int   n;
        int   mode;
        int   err_round;
        clock      = 1'b0;
        rst_n      = 1'b0;
        start      = 1'b0;
        keys       = '0;
        level      = 1'b0;
        lcg_state  = 82;
        repeat (2) @(posedge clock);
        #0.5;
        rst_n = 1'b1;
        next_cycle();
        check_value("reset done", 0, 32'(done));
        check_value("reset won", 0, 32'(won));
        check_value("reset lost", 0, 32'(lost));
        check_value("reset timed_out", 0, 32'(timed_out));
        check_value("reset round", 0, 32'(round));
        check_value("reset play", 0, 32'(play));
        // Fixed opening games for the short level, the long level and long key holds
        run_game(0, 1'b0, mode_win, 0, 1'b0);
        run_game(1, 1'b1, mode_win, 0, 1'b0);
        run_game(2, 1'b0, mode_win, 0, 1'b1);
        for (int g = 3; g < game_count; g++) begin
            long_level = (rand_range(0, 1) == 1);
            n          = long_level ? game_pkg::rounds_long : game_pkg::rounds_short;
            mode       = int'(rand_range(0, 2));
            err_round  = int'(rand_range(0, n - 1));
            long_hold  = (rand_range(0, 3) == 0);
            run_game(g, long_level, mode, err_round, long_hold);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== verif/memory_game_checker.sv ====
// Memory game checker with assertions on the control FSM outputs
`timescale 1ns/100ps

module memory_game_checker (
    input logic clock,
    input logic rst_n,
    input logic count_round,
    input logic clear_round,
    input logic timer_run,
    input logic done,
    input logic won,
    input logic lost,
    input logic timed_out
);

    // Exactly one verdict once the game is over
    verdict_one_hot: assert property (@(posedge clock) disable iff (!rst_n)
        done |-> (won ^ lost))
        else $error("done is high without exactly one of won and lost");

    // Timeout is a kind of loss
    timeout_is_loss: assert property (@(posedge clock) disable iff (!rst_n)
        timed_out |-> lost)
        else $error("timed_out is high while lost is low");

    // Round strobes are exclusive
    round_strobes: assert property (@(posedge clock) disable iff (!rst_n)
        !(count_round && clear_round))
        else $error("count_round and clear_round are high together");

    // Timer idle after the game
    timer_stopped: assert property (@(posedge clock) disable iff (!rst_n)
        !(timer_run && done))
        else $error("timer_run is high while done is high");

endmodule

// ==== design/memory_game.sv ====
// Memory game top level joining datapath, play timer and control FSM
`timescale 1ns/100ps

module memory_game #(
    parameter int timeout_cycles = 64
) (
    input  logic                             clock,
    input  logic                             rst_n,
    input  logic                             start,
    input  logic [game_pkg::key_width-1:0]   keys,
    input  logic                             level,
    output logic                             done,
    output logic                             won,
    output logic                             lost,
    output logic                             timed_out,
    output logic [game_pkg::key_width-1:0]   play,
    output logic [game_pkg::round_width-1:0] round
);

    // Control to datapath
    logic clear_regs;
    logic store_play;
    logic store_level;
    logic clear_round;
    logic count_round;

    // Datapath to control
    logic new_play;
    logic match;
    logic last_round;

    // Timer handshake with control
    logic timer_clear;
    logic timer_run;
    logic timeout;

    game_datapath i_game_datapath (
        .clock       (clock),
        .rst_n       (rst_n),
        .keys        (keys),
        .level       (level),
        .clear_regs  (clear_regs),
        .store_play  (store_play),
        .store_level (store_level),
        .clear_round (clear_round),
        .count_round (count_round),
        .new_play    (new_play),
        .match       (match),
        .last_round  (last_round),
        .play        (play),
        .round       (round)
    );

    play_timer #(
        .timeout_cycles (timeout_cycles)
    ) i_play_timer (
        .clock       (clock),
        .rst_n       (rst_n),
        .timer_clear (timer_clear),
        .timer_run   (timer_run),
        .timeout     (timeout)
    );

    game_control i_game_control (
        .clock       (clock),
        .rst_n       (rst_n),
        .start       (start),
        .new_play    (new_play),
        .match       (match),
        .last_round  (last_round),
        .timeout     (timeout),
        .clear_regs  (clear_regs),
        .store_play  (store_play),
        .store_level (store_level),
        .clear_round (clear_round),
        .count_round (count_round),
        .timer_clear (timer_clear),
        .timer_run   (timer_run),
        .done        (done),
        .won         (won),
        .lost        (lost),
        .timed_out   (timed_out)
    );

endmodule

// ==== design/game_control.sv ====
// Game control FSM that sequences start, plays, compares and the game verdict
`timescale 1ns/100ps

module game_control (
    input  logic clock,
    input  logic rst_n,
    input  logic start,
    // Conditions from datapath and timer
    input  logic new_play,
    input  logic match,
    input  logic last_round,
    input  logic timeout,
    // Datapath strobes
    output logic clear_regs,
    output logic store_play,
    output logic store_level,
    output logic clear_round,
    output logic count_round,
    // Timer control
    output logic timer_clear,
    output logic timer_run,
    // Game status
    output logic done,
    output logic won,
    output logic lost,
    output logic timed_out
);

    game_pkg::game_state_t state;
    game_pkg::game_state_t next_state;

    logic start_game;
    logic time_up;

    // Start is taken only when no game is running
    assign start_game = start && ((state == game_pkg::idle) ||
                                  (state == game_pkg::won_state) ||
                                  (state == game_pkg::lost_state));

    // Timeout counts only while a play is awaited
    assign time_up = (state == game_pkg::wait_play) && timeout;

    // State register
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= game_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    // Next state
    always_comb begin
        next_state = state;
        unique case (state)
            game_pkg::idle: begin
                if (start) begin
                    next_state = game_pkg::prepare;
                end
            end
            game_pkg::prepare: begin
                next_state = game_pkg::wait_play;
            end
            game_pkg::wait_play: begin
                // Timeout wins over a play in the same cycle
                if (timeout) begin
                    next_state = game_pkg::lost_state;
                end else if (new_play) begin
                    next_state = game_pkg::store_play;
                end
            end
            game_pkg::store_play: begin
                next_state = game_pkg::compare;
            end
            game_pkg::compare: begin
                if (!match) begin
                    next_state = game_pkg::lost_state;
                end else if (last_round) begin
                    next_state = game_pkg::won_state;
                end else begin
                    next_state = game_pkg::next_round;
                end
            end
            game_pkg::next_round: begin
                next_state = game_pkg::wait_play;
            end
            game_pkg::won_state, game_pkg::lost_state: begin
                // Verdict holds until a new start
                if (start) begin
                    next_state = game_pkg::prepare;
                end
            end
            default: begin
                next_state = game_pkg::idle;
            end
        endcase
    end

    // Moore outputs decoded from the state
    always_comb begin
        clear_regs  = 1'b0;
        store_play  = 1'b0;
        store_level = 1'b0;
        clear_round = 1'b0;
        count_round = 1'b0;
        timer_clear = 1'b0;
        timer_run   = 1'b0;
        done        = 1'b0;
        won         = 1'b0;
        lost        = 1'b0;
        unique case (state)
            game_pkg::prepare: begin
                clear_regs  = 1'b1;
                store_level = 1'b1;
                clear_round = 1'b1;
                timer_clear = 1'b1;
            end
            game_pkg::wait_play: begin
                timer_run = 1'b1;
            end
            game_pkg::store_play: begin
                store_play = 1'b1;
            end
            game_pkg::next_round: begin
                count_round = 1'b1;
                timer_clear = 1'b1;
            end
            game_pkg::won_state: begin
                done = 1'b1;
                won  = 1'b1;
            end
            game_pkg::lost_state: begin
                done = 1'b1;
                lost = 1'b1;
            end
            default: begin
                // idle and compare drive nothing
            end
        endcase
    end

    // Timeout flag, set on the way to lost, cleared by a new game
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            timed_out <= 1'b0;
        end else if (start_game) begin
            timed_out <= 1'b0;
        end else if (time_up) begin
            timed_out <= 1'b1;
        end
    end

endmodule

// ==== design/play_timer.sv ====
// Play timer that counts cycles while a play is awaited and flags a timeout
`timescale 1ns/100ps

module play_timer #(
    parameter int timeout_cycles = 64
) (
    input  logic clock,
    input  logic rst_n,
    input  logic timer_clear,
    input  logic timer_run,
    output logic timeout
);

    // Wide enough to hold timeout_cycles itself
    localparam int count_width = $clog2(timeout_cycles + 1);
    localparam logic [count_width-1:0] count_limit = count_width'(timeout_cycles);

    logic [count_width-1:0] count;

    // Clear has priority, count stops at the limit
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (timer_clear) begin
            count <= '0;
        end else if (timer_run && (count != count_limit)) begin
            count <= count + 1'b1;
        end
    end

    // Holds once reached, until the next clear
    assign timeout = (count == count_limit);

endmodule

// ==== design/game_datapath.sv ====
// Game datapath with play and level registers, key edge detector, round counter and compare
`timescale 1ns/100ps

module game_datapath (
    input  logic                             clock,
    input  logic                             rst_n,
    input  logic [game_pkg::key_width-1:0]   keys,
    input  logic                             level,
    // Strobes from control
    input  logic                             clear_regs,
    input  logic                             store_play,
    input  logic                             store_level,
    input  logic                             clear_round,
    input  logic                             count_round,
    // Conditions to control
    output logic                             new_play,
    output logic                             match,
    output logic                             last_round,
    // Visible state
    output logic [game_pkg::key_width-1:0]   play,
    output logic [game_pkg::round_width-1:0] round
);

    localparam int round_w = game_pkg::round_width;

    // Final round index per level
    localparam logic [round_w-1:0] last_short = round_w'(game_pkg::rounds_short - 1);
    localparam logic [round_w-1:0] last_long  = round_w'(game_pkg::rounds_long - 1);

    logic [game_pkg::key_width-1:0] keys_q;
    logic                           any_key_d;
    logic                           level_q;
    logic [game_pkg::key_width-1:0] rom_word;

    // Key sampling and edge detector on the OR of the keys
    // keys_q also feeds the play register, so a short press is still stored
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            keys_q    <= '0;
            any_key_d <= 1'b0;
        end else begin
            keys_q    <= keys;
            any_key_d <= |keys_q;
        end
    end

    // One pulse per press, held keys give no more pulses
    assign new_play = (|keys_q) & ~any_key_d;

    // Play register
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            play <= '0;
        end else if (clear_regs) begin
            play <= '0;
        end else if (store_play) begin
            play <= keys_q;
        end
    end

    // Level register, a store wins over the clear in prepare
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            level_q <= 1'b0;
        end else if (store_level) begin
            level_q <= level;
        end else if (clear_regs) begin
            level_q <= 1'b0;
        end
    end

    // Round counter, also the ROM address
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            round <= '0;
        end else if (clear_round) begin
            round <= '0;
        end else if (count_round) begin
            round <= round + 1'b1;
        end
    end

    sequence_rom i_sequence_rom (
        .clock   (clock),
        .address (round),
        .data    (rom_word)
    );

    // Play against the stored word of this round
    assign match = (play == rom_word);

    // 7 for short, 15 for long
    assign last_round = (round == (level_q ? last_long : last_short));

endmodule

// ==== design/sequence_rom.sv ====
// Sequence ROM of 16 words by 4 bits with a registered read of the game sequence
`timescale 1ns/100ps

module sequence_rom (
    input  logic                             clock,
    input  logic [game_pkg::round_width-1:0] address,
    output logic [game_pkg::key_width-1:0]   data
);

    // Word read from the table for the current address
    logic [game_pkg::key_width-1:0] word;

    // Combinational table lookup
    always_comb begin
        word = game_pkg::game_sequence[address];
    end

    // Output register gives one cycle of read latency
    always_ff @(posedge clock) begin
        data <= word;
    end

endmodule

// ==== design/game_pkg.sv ====
// Memory game package with widths, round counts, stored key sequence and FSM states
package game_pkg;

    // Key, play and ROM word width
    localparam int key_width = 4;

    // Round counter width, enough for the long level
    localparam int round_width = 4;

    // Plays per level
    localparam int rounds_short = 8;
    localparam int rounds_long  = 16;

    // Stored sequence, one-hot key codes, entry 0 is the first play
    localparam logic [key_width-1:0] game_sequence [rounds_long] = '{
        4'b0001,
        4'b0010,
        4'b0100,
        4'b1000,
        4'b0100,
        4'b0010,
        4'b0001,
        4'b0001,
        4'b0010,
        4'b0010,
        4'b0100,
        4'b0100,
        4'b1000,
        4'b1000,
        4'b0001,
        4'b0100
    };

    // Control unit states
    typedef enum logic [2:0] {
        idle,
        prepare,
        wait_play,
        store_play,
        compare,
        next_round,
        won_state,
        lost_state
    } game_state_t;

endpackage
